/* Bender.yml */
package:
  name: data_periph_demux

sources:
  - rtl/periph_demux_pkg.sv
  - rtl/demux_route_if.sv
  - rtl/req_router.sv
  - rtl/pe_txn_ctrl.sv
  - rtl/resp_router.sv
  - rtl/perf_regs_apb.sv
  - rtl/data_periph_demux.sv
  - target: test
    files:
      - tests/tb_data_periph_demux.sv

/* flist.f */
rtl/periph_demux_pkg.sv
rtl/demux_route_if.sv
rtl/req_router.sv
rtl/pe_txn_ctrl.sv
rtl/resp_router.sv
rtl/perf_regs_apb.sv
rtl/data_periph_demux.sv
tests/tb_data_periph_demux.sv

/* rtl/data_periph_demux.sv */
/*
 * Data port demultiplexer, top level
 *   - core port to SH, EXT and PE targets
 *   - APB access to the stall counters
 *   - L2 performance strobes
 */

module data_periph_demux
  import periph_demux_pkg::*;
#(
  parameter int unsigned DATA_WIDTH         = 32,
  parameter int unsigned REMAP_ADDRESS      = 1,
  parameter int unsigned CLUSTER_ALIAS      = 1,
  parameter logic [11:0] CLUSTER_ALIAS_BASE = 12'h000,
  localparam int unsigned BE_W              = DATA_WIDTH / 8
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic [3:0]            base_addr_i,
  // Core side
  input  logic                  data_req_i,
  input  logic [ADDR_W-1:0]     data_add_i,
  input  logic                  data_wen_i,
  input  logic [DATA_WIDTH-1:0] data_wdata_i,
  input  logic [BE_W-1:0]       data_be_i,
  output logic                  data_gnt_o,
  output logic                  data_r_valid_o,
  output logic [DATA_WIDTH-1:0] data_r_rdata_o,
  output logic                  data_r_opc_o,
  // Shared TCDM
  output logic                  data_req_sh_o,
  output logic [ADDR_W-1:0]     data_add_sh_o,
  output logic                  data_wen_sh_o,
  output logic [DATA_WIDTH-1:0] data_wdata_sh_o,
  output logic [BE_W-1:0]       data_be_sh_o,
  input  logic                  data_gnt_sh_i,
  input  logic                  data_r_valid_sh_i,
  input  logic [DATA_WIDTH-1:0] data_r_rdata_sh_i,
  // Demux peripherals
  output logic                  data_req_ext_o,
  output logic [ADDR_W-1:0]     data_add_ext_o,
  output logic                  data_wen_ext_o,
  output logic [DATA_WIDTH-1:0] data_wdata_ext_o,
  output logic [BE_W-1:0]       data_be_ext_o,
  input  logic                  data_gnt_ext_i,
  input  logic                  data_r_valid_ext_i,
  input  logic [DATA_WIDTH-1:0] data_r_rdata_ext_i,
  input  logic                  data_r_opc_ext_i,
  // Peripheral interconnect
  output logic                  data_req_pe_o,
  output logic [ADDR_W-1:0]     data_add_pe_o,
  output logic                  data_wen_pe_o,
  output logic [DATA_WIDTH-1:0] data_wdata_pe_o,
  output logic [BE_W-1:0]       data_be_pe_o,
  input  logic                  data_gnt_pe_i,
  input  logic                  data_r_valid_pe_i,
  input  logic [DATA_WIDTH-1:0] data_r_rdata_pe_i,
  input  logic                  data_r_opc_pe_i,
  // APB
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [3:0]            paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  // Performance strobes
  output logic                  perf_l2_ld_o,
  output logic                  perf_l2_st_o,
  output logic                  perf_l2_ld_cyc_o,
  output logic                  perf_l2_st_cyc_o
);

  logic [ADDR_W-1:0]     add_int;       // Remapped address
  logic                  req_pe;
  logic                  gnt_pe;
  logic                  pe_r_valid;
  logic [DATA_WIDTH-1:0] pe_r_rdata;
  logic                  pe_r_opc;

  demux_route_if route ();

  // Request fields are common to every target
  assign data_add_sh_o    = add_int;
  assign data_wen_sh_o    = data_wen_i;
  assign data_wdata_sh_o  = data_wdata_i;
  assign data_be_sh_o     = data_be_i;
  assign data_add_ext_o   = add_int;
  assign data_wen_ext_o   = data_wen_i;
  assign data_wdata_ext_o = data_wdata_i;
  assign data_be_ext_o    = data_be_i;
  assign data_add_pe_o    = add_int;
  assign data_wen_pe_o    = data_wen_i;
  assign data_wdata_pe_o  = data_wdata_i;
  assign data_be_pe_o     = data_be_i;

  req_router #(
    .REMAP_ADDRESS      (REMAP_ADDRESS),
    .CLUSTER_ALIAS      (CLUSTER_ALIAS),
    .CLUSTER_ALIAS_BASE (CLUSTER_ALIAS_BASE)
  ) u_req_router (
    .base_addr_i (base_addr_i),
    .data_req_i  (data_req_i),
    .data_add_i  (data_add_i),
    .data_wen_i  (data_wen_i),
    .data_gnt_o  (data_gnt_o),
    .add_o       (add_int),
    .req_sh_o    (data_req_sh_o),
    .gnt_sh_i    (data_gnt_sh_i),
    .req_ext_o   (data_req_ext_o),
    .gnt_ext_i   (data_gnt_ext_i),
    .req_pe_o    (req_pe),
    .gnt_pe_i    (gnt_pe),
    .route       (route.router)
  );

  pe_txn_ctrl #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_pe_txn_ctrl (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .req_i        (req_pe),
    .gnt_o        (gnt_pe),
    .pe_req_o     (data_req_pe_o),
    .pe_gnt_i     (data_gnt_pe_i),
    .pe_r_valid_i (data_r_valid_pe_i),
    .pe_r_rdata_i (data_r_rdata_pe_i),
    .pe_r_opc_i   (data_r_opc_pe_i),
    .r_valid_o    (pe_r_valid),
    .r_rdata_o    (pe_r_rdata),
    .r_opc_o      (pe_r_opc)
  );

  resp_router #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_resp_router (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .route          (route.observer),
    .sh_r_valid_i   (data_r_valid_sh_i),
    .sh_r_rdata_i   (data_r_rdata_sh_i),
    .ext_r_valid_i  (data_r_valid_ext_i),
    .ext_r_rdata_i  (data_r_rdata_ext_i),
    .ext_r_opc_i    (data_r_opc_ext_i),
    .pe_r_valid_i   (pe_r_valid),
    .pe_r_rdata_i   (pe_r_rdata),
    .pe_r_opc_i     (pe_r_opc),
    .data_r_valid_o (data_r_valid_o),
    .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o   (data_r_opc_o)
  );

  perf_regs_apb u_perf_regs_apb (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .route            (route.observer),
    .psel_i           (psel_i),
    .penable_i        (penable_i),
    .pwrite_i         (pwrite_i),
    .paddr_i          (paddr_i),
    .pwdata_i         (pwdata_i),
    .prdata_o         (prdata_o),
    .perf_l2_ld_o     (perf_l2_ld_o),
    .perf_l2_st_o     (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
    .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

endmodule

/* rtl/demux_route_if.sv */
/*
 * Routed request summary, driven by the request router
 * and watched by the response router and the perf block
 */

interface demux_route_if
  import periph_demux_pkg::*;
();

  logic        req;   // Core request valid
  demux_dest_e dest;  // Decoded target
  logic        gnt;   // Grant returned to the core
  logic        wen;   // 1 = load

  modport router (output req, output dest, output gnt, output wen);

  modport observer (input req, input dest, input gnt, input wen);

endinterface

/* rtl/pe_txn_ctrl.sv */
/*
 * PE transaction controller
 *   - one outstanding request toward the peripheral interconnect
 *   - core grant issued after the PE response
 *   - two register stages on the response path
 */

module pe_txn_ctrl #(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  req_i,
  output logic                  gnt_o,
  output logic                  pe_req_o,
  input  logic                  pe_gnt_i,
  input  logic                  pe_r_valid_i,
  input  logic [DATA_WIDTH-1:0] pe_r_rdata_i,
  input  logic                  pe_r_opc_i,
  output logic                  r_valid_o,
  output logic [DATA_WIDTH-1:0] r_rdata_o,
  output logic                  r_opc_o
);

  typedef enum logic [1:0] {
    IDLE,
    PENDING,
    GRANTED
  } state_e;

  state_e                cs, ns;
  logic                  valid_0;
  logic [DATA_WIDTH-1:0] rdata_0;
  logic                  opc_0;

  always_ff @(posedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
      cs <= IDLE;
    else
      cs <= ns;
  end

  always_comb
  begin
    ns       = cs;
    pe_req_o = 1'b0;
    gnt_o    = 1'b0;
    case (cs)
      IDLE:
      begin
        pe_req_o = req_i;  // Straight through while idle
        if (req_i && pe_gnt_i)
          ns = PENDING;
      end
      PENDING:
      begin
        if (pe_r_valid_i)
          ns = GRANTED;
      end
      GRANTED:
      begin
        gnt_o = 1'b1;  // Core sees its grant now
        ns    = IDLE;
      end
      default: ns = IDLE;
    endcase
  end

  // ****************************************
  // Response stages
  always_ff @(posedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_0   <= 1'b0;
      r_valid_o <= 1'b0;
    end
    else
    begin
      valid_0   <= pe_r_valid_i;
      r_valid_o <= valid_0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pe_r_valid_i)
    begin
      rdata_0 <= pe_r_rdata_i;
      opc_0   <= pe_r_opc_i;
    end
    if (valid_0)
    begin
      r_rdata_o <= rdata_0;
      r_opc_o   <= opc_0;
    end
  end

endmodule

/* rtl/perf_regs_apb.sv */
/*
 * Performance block
 *   - APB control register (enable, clear)
 *   - SH and L2 stall counters, readable over APB
 *   - L2 load/store strobes
 */

module perf_regs_apb
  import periph_demux_pkg::*;
(
  input  logic            clk,
  input  logic            rst_ni,
  demux_route_if.observer route,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [3:0]      paddr_i,
  input  logic [31:0]     pwdata_i,
  output logic [31:0]     prdata_o,
  output logic            perf_l2_ld_o,
  output logic            perf_l2_st_o,
  output logic            perf_l2_ld_cyc_o,
  output logic            perf_l2_st_cyc_o
);

  logic             en_q;
  logic             ctrl_wr;
  logic             clr;
  logic             sh_req;
  logic             l2_req;
  logic [CNT_W-1:0] stall_sh_q;
  logic [CNT_W-1:0] stall_l2_q;

  assign sh_req = route.req && (route.dest == DEST_SH);
  assign l2_req = route.req && (route.dest != DEST_SH);  // PE or EXT

  // ****************************************
  // L2 strobes
  assign perf_l2_ld_o     = l2_req & route.gnt & route.wen;
  assign perf_l2_st_o     = l2_req & route.gnt & ~route.wen;
  assign perf_l2_ld_cyc_o = l2_req & route.wen;
  assign perf_l2_st_cyc_o = l2_req & ~route.wen;

  // ****************************************
  // APB side
  assign ctrl_wr = psel_i && penable_i && pwrite_i && (paddr_i == REG_CTRL);
  assign clr     = ctrl_wr && pwdata_i[1];  // Self clearing

  always_ff @(posedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
      en_q <= 1'b0;
    else if (ctrl_wr)
      en_q <= pwdata_i[0];
  end

  always_comb
  begin
    prdata_o = '0;
    if (psel_i && !pwrite_i)
    begin
      case (paddr_i)
        REG_CTRL:     prdata_o = {31'b0, en_q};
        REG_STALL_SH: prdata_o = stall_sh_q;
        REG_STALL_L2: prdata_o = stall_l2_q;
        default:      prdata_o = '0;
      endcase
    end
  end

  // Stall counters, one cycle behind the stall
  always_ff @(posedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stall_sh_q <= '0;
      stall_l2_q <= '0;
    end
    else if (clr)
    begin
      stall_sh_q <= '0;
      stall_l2_q <= '0;
    end
    else if (en_q)
    begin
      if (sh_req && !route.gnt)
        stall_sh_q <= stall_sh_q + 1'b1;
      if (l2_req && !route.gnt)
        stall_l2_q <= stall_l2_q + 1'b1;
    end
  end

endmodule

/* rtl/periph_demux_pkg.sv */
/*
 * Shared definitions of the data port demultiplexer:
 *   - target enum and the two views of a 32-bit address
 *   - region offsets of the default memory map
 *   - nibble swap value and EXT select bit
 *   - stall counter width and APB register map
 */

package periph_demux_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned CNT_W  = 32;

  typedef enum logic [1:0] {
    DEST_SH,   // Shared TCDM
    DEST_PE,   // Peripheral interconnect
    DEST_EXT   // Demux peripherals
  } demux_dest_e;

  typedef struct packed {
    logic [3:0]  nib;
    logic [27:0] rest;
  } addr_remap_t;

  typedef struct packed {
    logic [11:0] tag;
    logic [5:0]  sub;
    logic [13:0] low;
  } addr_region_t;

  // Same word, decoded for the swap and for the region
  typedef union packed {
    addr_remap_t  remap;
    addr_region_t region;
  } demux_addr_u;

  // Region offsets from the base tag
  localparam logic [11:0] TCDM_RW_OFS = 12'd0;
  localparam logic [11:0] TCDM_TS_OFS = 12'd1;
  localparam logic [11:0] DEM_PER_OFS = 12'd2;

  localparam logic [3:0]  REMAP_NIB   = 4'h1;
  localparam int unsigned EXT_SEL_BIT = 14;

  // APB register map
  localparam logic [3:0] REG_CTRL     = 4'h0;  // [0] enable, [1] clear
  localparam logic [3:0] REG_STALL_SH = 4'h4;
  localparam logic [3:0] REG_STALL_L2 = 4'h8;

endpackage

/* rtl/req_router.sv */
/*
 * Request router
 *   - optional swap of the top nibble with the cluster base
 *   - destination decode with cluster alias
 *   - request steering and grant selection
 */

module req_router
  import periph_demux_pkg::*;
#(
  parameter int unsigned REMAP_ADDRESS      = 1,
  parameter int unsigned CLUSTER_ALIAS      = 1,
  parameter logic [11:0] CLUSTER_ALIAS_BASE = 12'h000
) (
  input  logic [3:0]    base_addr_i,
  input  logic          data_req_i,
  input  demux_addr_u   data_add_i,
  input  logic          data_wen_i,
  output logic          data_gnt_o,
  output demux_addr_u   add_o,
  output logic          req_sh_o,
  input  logic          gnt_sh_i,
  output logic          req_ext_o,
  input  logic          gnt_ext_i,
  output logic          req_pe_o,
  input  logic          gnt_pe_i,
  demux_route_if.router route
);

  demux_addr_u add_int;
  demux_dest_e dest;
  logic [11:0] ofs_base;   // Tag distance from the cluster base
  logic [11:0] ofs_alias;  // Tag distance from the alias base
  logic        alias_en;

  // base nibble <-> 4'h1, everything else unchanged
  always_comb
  begin
    add_int = data_add_i;
    if (REMAP_ADDRESS == 1)
    begin
      if (data_add_i.remap.nib == base_addr_i)
        add_int.remap.nib = REMAP_NIB;
      else if (data_add_i.remap.nib == REMAP_NIB)
        add_int.remap.nib = base_addr_i;
    end
  end

  assign add_o     = add_int;
  assign alias_en  = (CLUSTER_ALIAS == 1);
  assign ofs_base  = add_int.region.tag - {base_addr_i, 8'h00};
  assign ofs_alias = add_int.region.tag - CLUSTER_ALIAS_BASE;

  // ****************************************
  // Region decode
  always_comb
  begin
    dest = DEST_PE;  // Cluster peripherals and the rest of the map
    if (ofs_base == TCDM_RW_OFS || ofs_base == TCDM_TS_OFS)
      dest = DEST_SH;
    else if (alias_en && (ofs_alias == TCDM_RW_OFS || ofs_alias == TCDM_TS_OFS))
      dest = DEST_SH;
    else if (ofs_base == DEM_PER_OFS || (alias_en && ofs_alias == DEM_PER_OFS))
      dest = add_int[EXT_SEL_BIT] ? DEST_EXT : DEST_PE;
  end

  assign req_sh_o  = data_req_i && (dest == DEST_SH);
  assign req_ext_o = data_req_i && (dest == DEST_EXT);
  assign req_pe_o  = data_req_i && (dest == DEST_PE);

  always_comb
  begin
    case (dest)
      DEST_SH:  data_gnt_o = gnt_sh_i;
      DEST_EXT: data_gnt_o = gnt_ext_i;
      DEST_PE:  data_gnt_o = gnt_pe_i;
      default:  data_gnt_o = 1'b0;
    endcase
  end

  assign route.req  = data_req_i;
  assign route.dest = dest;
  assign route.gnt  = data_gnt_o;
  assign route.wen  = data_wen_i;

endmodule

/* rtl/resp_router.sv */
/*
 * Response router
 *   - destination register, loaded on each accepted request
 *   - response mux over SH, PE and EXT
 */

module resp_router
  import periph_demux_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_ni,
  demux_route_if.observer        route,
  input  logic                   sh_r_valid_i,
  input  logic [DATA_WIDTH-1:0]  sh_r_rdata_i,
  input  logic                   ext_r_valid_i,
  input  logic [DATA_WIDTH-1:0]  ext_r_rdata_i,
  input  logic                   ext_r_opc_i,
  input  logic                   pe_r_valid_i,
  input  logic [DATA_WIDTH-1:0]  pe_r_rdata_i,
  input  logic                   pe_r_opc_i,
  output logic                   data_r_valid_o,
  output logic [DATA_WIDTH-1:0]  data_r_rdata_o,
  output logic                   data_r_opc_o
);

  demux_dest_e dest_q;

  always_ff @(posedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
      dest_q <= DEST_SH;
    else if (route.req && route.gnt)
      dest_q <= route.dest;  // Only accepted requests move it
  end

  always_comb
  begin
    case (dest_q)
      DEST_PE:
      begin
        data_r_valid_o = pe_r_valid_i;
        data_r_rdata_o = pe_r_rdata_i;
        data_r_opc_o   = pe_r_opc_i;
      end
      DEST_EXT:
      begin
        data_r_valid_o = ext_r_valid_i;
        data_r_rdata_o = ext_r_rdata_i;
        data_r_opc_o   = ext_r_opc_i;
      end
      DEST_SH:
      begin
        data_r_valid_o = sh_r_valid_i;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;  // TCDM never errors
      end
      default:
      begin
        data_r_valid_o = 1'b0;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;
      end
    endcase
  end

endmodule

/* tests/tb_data_periph_demux.sv */
/*
 * Testbench of the data port demultiplexer
 *   - behavioral SH, EXT and PE target models
 *   - core request and APB access tasks
 *   - directed tests for routing, PE transactions and stall counters
 */

module target_model #(
  parameter logic [31:0] KEY = 32'h0
) (
  input  logic        clk,
  input  logic        rst_ni,
  input  int          delay_i,    // Stall cycles before the grant
  input  logic        req_i,
  input  logic [31:0] add_i,
  output logic        gnt_o,
  output logic        r_valid_o,
  output logic [31:0] r_rdata_o,
  output logic        r_opc_o
);

  int          wait_cnt;
  logic        req_q;
  logic        acc_q;
  logic [31:0] add_q;

  initial
  begin
    gnt_o     = 1'b0;
    r_valid_o = 1'b0;
    r_rdata_o = '0;
    r_opc_o   = 1'b0;
  end

  // Sample the request where it is stable
  always @(posedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wait_cnt <= 0;
      req_q    <= 1'b0;
      acc_q    <= 1'b0;
      add_q    <= '0;
    end
    else
    begin
      req_q <= req_i;
      acc_q <= req_i && gnt_o;
      if (req_i && gnt_o)
      begin
        wait_cnt <= 0;
        add_q    <= add_i;
      end
      else if (req_i)
        wait_cnt <= wait_cnt + 1;
    end
  end

  // Grant and response change on the falling edge
  always @(negedge clk or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      gnt_o     <= 1'b0;
      r_valid_o <= 1'b0;
    end
    else
    begin
      gnt_o     <= req_q && !acc_q && (wait_cnt >= delay_i);
      r_valid_o <= acc_q;  // One cycle after the grant
      if (acc_q)
      begin
        r_rdata_o <= add_q ^ KEY;
        r_opc_o   <= add_q[2];
      end
    end
  end

endmodule

module tb_data_periph_demux
  import periph_demux_pkg::*;
();

  localparam int unsigned MAX_CYCLES = 2000;  // Wide margin over the whole test sequence
  localparam logic [31:0] SH_KEY     = 32'hA5A5_0000;
  localparam logic [31:0] EXT_KEY    = 32'h5A5A_0000;
  localparam logic [31:0] PE_KEY     = 32'h3C3C_0000;

  logic        clk;
  logic        rst_ni;
  logic [3:0]  base_addr_i;
  logic        data_req_i;
  logic [31:0] data_add_i;
  logic        data_wen_i;
  logic [31:0] data_wdata_i;
  logic [3:0]  data_be_i;
  logic        data_gnt_o;
  logic        data_r_valid_o;
  logic [31:0] data_r_rdata_o;
  logic        data_r_opc_o;
  logic        data_req_sh_o, data_wen_sh_o, data_gnt_sh_i, data_r_valid_sh_i;
  logic [31:0] data_add_sh_o, data_wdata_sh_o, data_r_rdata_sh_i;
  logic [3:0]  data_be_sh_o;
  logic        data_req_ext_o, data_wen_ext_o, data_gnt_ext_i, data_r_valid_ext_i;
  logic        data_r_opc_ext_i;
  logic [31:0] data_add_ext_o, data_wdata_ext_o, data_r_rdata_ext_i;
  logic [3:0]  data_be_ext_o;
  logic        data_req_pe_o, data_wen_pe_o, data_gnt_pe_i, data_r_valid_pe_i;
  logic        data_r_opc_pe_i;
  logic [31:0] data_add_pe_o, data_wdata_pe_o, data_r_rdata_pe_i;
  logic [3:0]  data_be_pe_o;
  logic        psel_i, penable_i, pwrite_i;
  logic [3:0]  paddr_i;
  logic [31:0] pwdata_i, prdata_o;
  logic        perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o;

  int seed = 76365;
  int errors;
  int other_errors;
  int checks;
  int cycle_cnt;
  int pe_req_cycles;  // Cycles with a PE request seen at the rising edge
  int sh_delay  = 1;
  int ext_delay = 1;
  int pe_delay  = 1;

  data_periph_demux u_data_periph_demux (
    .clk (clk), .rst_ni (rst_ni), .base_addr_i (base_addr_i),
    .data_req_i (data_req_i), .data_add_i (data_add_i), .data_wen_i (data_wen_i),
    .data_wdata_i (data_wdata_i), .data_be_i (data_be_i), .data_gnt_o (data_gnt_o),
    .data_r_valid_o (data_r_valid_o), .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o (data_r_opc_o),
    .data_req_sh_o (data_req_sh_o), .data_add_sh_o (data_add_sh_o),
    .data_wen_sh_o (data_wen_sh_o), .data_wdata_sh_o (data_wdata_sh_o),
    .data_be_sh_o (data_be_sh_o), .data_gnt_sh_i (data_gnt_sh_i),
    .data_r_valid_sh_i (data_r_valid_sh_i), .data_r_rdata_sh_i (data_r_rdata_sh_i),
    .data_req_ext_o (data_req_ext_o), .data_add_ext_o (data_add_ext_o),
    .data_wen_ext_o (data_wen_ext_o), .data_wdata_ext_o (data_wdata_ext_o),
    .data_be_ext_o (data_be_ext_o), .data_gnt_ext_i (data_gnt_ext_i),
    .data_r_valid_ext_i (data_r_valid_ext_i), .data_r_rdata_ext_i (data_r_rdata_ext_i),
    .data_r_opc_ext_i (data_r_opc_ext_i),
    .data_req_pe_o (data_req_pe_o), .data_add_pe_o (data_add_pe_o),
    .data_wen_pe_o (data_wen_pe_o), .data_wdata_pe_o (data_wdata_pe_o),
    .data_be_pe_o (data_be_pe_o), .data_gnt_pe_i (data_gnt_pe_i),
    .data_r_valid_pe_i (data_r_valid_pe_i), .data_r_rdata_pe_i (data_r_rdata_pe_i),
    .data_r_opc_pe_i (data_r_opc_pe_i),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
    .perf_l2_ld_o (perf_l2_ld_o), .perf_l2_st_o (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o), .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  target_model #(.KEY(SH_KEY)) u_sh_model (
    .clk (clk), .rst_ni (rst_ni), .delay_i (sh_delay), .req_i (data_req_sh_o),
    .add_i (data_add_sh_o), .gnt_o (data_gnt_sh_i), .r_valid_o (data_r_valid_sh_i),
    .r_rdata_o (data_r_rdata_sh_i), .r_opc_o ()
  );

  target_model #(.KEY(EXT_KEY)) u_ext_model (
    .clk (clk), .rst_ni (rst_ni), .delay_i (ext_delay), .req_i (data_req_ext_o),
    .add_i (data_add_ext_o), .gnt_o (data_gnt_ext_i), .r_valid_o (data_r_valid_ext_i),
    .r_rdata_o (data_r_rdata_ext_i), .r_opc_o (data_r_opc_ext_i)
  );

  target_model #(.KEY(PE_KEY)) u_pe_model (
    .clk (clk), .rst_ni (rst_ni), .delay_i (pe_delay), .req_i (data_req_pe_o),
    .add_i (data_add_pe_o), .gnt_o (data_gnt_pe_i), .r_valid_o (data_r_valid_pe_i),
    .r_rdata_o (data_r_rdata_pe_i), .r_opc_o (data_r_opc_pe_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ****************************************
  // Cycle counter and run limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (data_req_pe_o)
      pe_req_cycles++;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      other_errors++;
      $display("Run stopped after %0d cycles, a handshake never completed", cycle_cnt);
      $display("Summary: %0d checks, %0d check errors, %0d other errors",
               checks, errors, other_errors);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  // Request fields as seen on one target port
  task automatic compare_port_fields(input string port, input logic [31:0] add,
                                     input logic wen, input logic [31:0] wdata,
                                     input logic [3:0] be, input logic [31:0] exp_add);
    check_value({"data_add_", port, "_o"}, add, exp_add);
    check_value({"data_wen_", port, "_o"}, wen, data_wen_i);
    check_value({"data_wdata_", port, "_o"}, wdata, data_wdata_i);
    check_value({"data_be_", port, "_o"}, be, data_be_i);
  endtask

  function automatic int draw_delay(input int lo, input int hi);
    int r;
    r = $unsigned($random(seed)) % (hi - lo + 1);
    return lo + r;
  endfunction

  // Base nibble and 4'h1 trade places and all else passes
  function automatic logic [31:0] remap_addr(input logic [31:0] addr, input logic [3:0] base);
    logic [31:0] res;
    res = addr;
    if (addr[31:28] == base)
      res[31:28] = REMAP_NIB;
    else if (addr[31:28] == REMAP_NIB)
      res[31:28] = base;
    return res;
  endfunction

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk);
    penable_i = 1'b1;
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata);
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(negedge clk);
    penable_i = 1'b1;
    @(posedge clk);
    rdata = prdata_o;  // Access phase
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // Core request held until the grant returns
  task automatic issue_request(input logic [31:0] addr, input logic wen,
                               input logic [31:0] wdata, input demux_dest_e exp_dest,
                               input logic check_l2, output int cycles,
                               output logic pe_rv_prev);
    logic        granted;
    logic        rv_last;
    logic [31:0] exp_add;
    exp_add = remap_addr(addr, base_addr_i);
    @(negedge clk);
    data_req_i   = 1'b1;
    data_add_i   = addr;
    data_wen_i   = wen;
    data_wdata_i = wdata;
    data_be_i    = ~addr[3:0];
    cycles       = 0;
    granted      = 1'b0;
    rv_last      = 1'b0;
    pe_rv_prev   = 1'b0;
    while (!granted)
    begin
      @(posedge clk);
      cycles++;
      granted    = data_gnt_o;
      pe_rv_prev = rv_last;
      rv_last    = data_r_valid_pe_i;
      if (cycles == 1)
      begin
        check_value("data_req_sh_o", data_req_sh_o, exp_dest == DEST_SH);
        check_value("data_req_ext_o", data_req_ext_o, exp_dest == DEST_EXT);
        check_value("data_req_pe_o", data_req_pe_o, exp_dest == DEST_PE);
        compare_port_fields("sh", data_add_sh_o, data_wen_sh_o, data_wdata_sh_o,
                            data_be_sh_o, exp_add);
        compare_port_fields("ext", data_add_ext_o, data_wen_ext_o, data_wdata_ext_o,
                            data_be_ext_o, exp_add);
        compare_port_fields("pe", data_add_pe_o, data_wen_pe_o, data_wdata_pe_o,
                            data_be_pe_o, exp_add);
      end
      if (check_l2)
      begin
        check_value("perf_l2_ld_cyc_o", perf_l2_ld_cyc_o, wen);
        check_value("perf_l2_st_cyc_o", perf_l2_st_cyc_o, !wen);
        check_value("perf_l2_ld_o", perf_l2_ld_o, wen && data_gnt_ext_i);
        check_value("perf_l2_st_o", perf_l2_st_o, !wen && data_gnt_ext_i);
      end
    end
    @(negedge clk);
    data_req_i = 1'b0;
  endtask

  task automatic wait_response(input string path, input logic [31:0] exp_rdata,
                               input logic exp_opc);
    int waited;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
    end while (!data_r_valid_o && waited < 8);
    if (!data_r_valid_o)
    begin
      other_errors++;
      $display("No %s response reached the core within 8 cycles", path);
    end
    else
    begin
      check_value("data_r_valid_o cycles after grant", waited, 1);
      check_value("data_r_rdata_o", data_r_rdata_o, exp_rdata);
      check_value("data_r_opc_o", data_r_opc_o, exp_opc);
    end
  endtask

  // ****************************************
  // Directed tests
  task automatic reset_values();
    logic [31:0] rd;
    @(posedge clk);
    check_value("data_r_valid_o", data_r_valid_o, 0);
    check_value("data_req_pe_o", data_req_pe_o, 0);
    check_value("data_gnt_o", data_gnt_o, 0);
    check_value("perf_l2_ld_o", perf_l2_ld_o, 0);
    check_value("perf_l2_st_o", perf_l2_st_o, 0);
    check_value("perf_l2_ld_cyc_o", perf_l2_ld_cyc_o, 0);
    check_value("perf_l2_st_cyc_o", perf_l2_st_cyc_o, 0);
    check_value("prdata_o", prdata_o, 0);
    apb_read(REG_CTRL, rd);
    check_value("REG_CTRL", rd, 0);
    apb_read(REG_STALL_SH, rd);
    check_value("REG_STALL_SH", rd, 0);
    apb_read(REG_STALL_L2, rd);
    check_value("REG_STALL_L2", rd, 0);
  endtask

  task automatic sh_access(input logic [31:0] addr, input logic wen);
    int   cycles;
    logic rv;
    sh_delay = draw_delay(1, 4);
    issue_request(addr, wen, ~addr, DEST_SH, 1'b0, cycles, rv);
    check_value("data_gnt_o cycles (SH)", cycles, sh_delay + 1);
    wait_response("SH", remap_addr(addr, base_addr_i) ^ SH_KEY, 1'b0);
  endtask

  task automatic sh_routing();
    @(negedge clk);
    base_addr_i = 4'h1;
    sh_access(32'h1000_0044, 1'b1);  // TCDM read/write
    sh_access(32'h1010_0084, 1'b0);  // Test-and-set
    sh_access(32'h0000_1004, 1'b1);  // Cluster alias
  endtask

  task automatic ext_access(input logic [31:0] addr, input logic wen);
    int          cycles;
    logic        rv;
    logic [31:0] exp_add;
    exp_add   = remap_addr(addr, base_addr_i);
    ext_delay = draw_delay(1, 4);
    issue_request(addr, wen, 32'hCAFE_0000 | addr[15:0], DEST_EXT, 1'b1, cycles, rv);
    check_value("data_gnt_o cycles (EXT)", cycles, ext_delay + 1);
    wait_response("EXT", exp_add ^ EXT_KEY, exp_add[2]);
  endtask

  task automatic ext_routing();
    ext_access(32'h1020_4004, 1'b1);
    ext_access(32'h1020_7FF8, 1'b0);
  endtask

  task automatic pe_access(input logic [31:0] addr, input logic wen);
    int          cycles;
    logic        rv;
    logic [31:0] exp_add;
    @(negedge clk);
    exp_add       = remap_addr(addr, base_addr_i);
    pe_delay      = draw_delay(1, 4);
    pe_req_cycles = 0;
    issue_request(addr, wen, ~addr, DEST_PE, 1'b0, cycles, rv);
    check_value("data_gnt_o cycles (PE)", cycles, pe_delay + 3);
    check_value("data_r_valid_pe_i before data_gnt_o", rv, 1);
    check_value("data_req_pe_o cycles", pe_req_cycles, pe_delay + 1);
    wait_response("PE", exp_add ^ PE_KEY, exp_add[2]);
  endtask

  task automatic pe_transaction();
    pe_access(32'h2000_000C, 1'b1);  // Outside every cluster region
    pe_access(32'h1020_0010, 1'b0);  // Demux peripherals with bit 14 clear
  endtask

  task automatic pe_remap();
    @(negedge clk);
    base_addr_i = 4'h5;
    pe_access(32'h5800_0010, 1'b1);  // Shows up as 0x1800_0010
    sh_access(32'h1000_0020, 1'b1);  // Shows up as 0x5000_0020
    @(negedge clk);
    base_addr_i = 4'h1;
  endtask

  task automatic stall_counting();
    int          n;
    logic [31:0] rd;
    apb_write(REG_CTRL, 32'h1);
    apb_read(REG_CTRL, rd);
    check_value("REG_CTRL", rd, 1);
    sh_access(32'h1000_0100, 1'b1);
    n = sh_delay;
    apb_read(REG_STALL_SH, rd);
    check_value("REG_STALL_SH", rd, n);
    apb_read(REG_STALL_L2, rd);
    check_value("REG_STALL_L2", rd, 0);
    pe_access(32'h3000_0000, 1'b1);
    apb_read(REG_STALL_L2, rd);
    check_value("REG_STALL_L2", rd, pe_delay + 2);  // PE wait plus the pending cycle
    apb_read(REG_STALL_SH, rd);
    check_value("REG_STALL_SH", rd, n);
    apb_write(REG_CTRL, 32'h2);
    apb_read(REG_STALL_SH, rd);
    check_value("REG_STALL_SH", rd, 0);
    apb_read(REG_STALL_L2, rd);
    check_value("REG_STALL_L2", rd, 0);
  endtask

  initial
  begin
    errors        = 0;
    other_errors  = 0;
    checks        = 0;
    cycle_cnt     = 0;
    pe_req_cycles = 0;
    rst_ni        = 1'b0;
    base_addr_i   = 4'h1;
    data_req_i    = 1'b0;
    data_add_i    = '0;
    data_wen_i    = 1'b1;
    data_wdata_i  = '0;
    data_be_i     = '0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    paddr_i       = '0;
    pwdata_i      = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;
    reset_values();
    sh_routing();
    ext_routing();
    pe_transaction();
    pe_remap();
    stall_counting();
    repeat (2) @(negedge clk);
    $display("Summary: %0d checks, %0d check errors, %0d other errors",
             checks, errors, other_errors);
    if (errors == 0 && other_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
